/* design/pcu_ctrl.sv */
`timescale 1ns/1ps

module pcu_ctrl #(
   parameter pcu_pkg::pc_word_t RESET_PC = '0,
   parameter int                WITH_CSR = 1
) (
   input  logic                  clk,
   input  logic                  i_reset,
   input  pcu_pkg::pcu_strobes_t i_strobes,
   input  logic                  i_jump,
   input  logic                  i_jal_or_jalr,
   input  logic                  i_utype,
   input  logic                  i_pc_rel,
   input  logic                  i_trap,
   input  logic                  i_imm,
   input  logic                  i_buf,
   input  logic                  i_csr_pc,
   input  logic                  i_ibus_ack,
   output logic                  o_rd_bit,
   output logic                  o_bad_pc_bit,
   output pcu_pkg::pc_word_t     o_ibus_adr,
   output logic                  o_ibus_cyc
);

   logic en_pc_r;
   logic pc;
   logic plus_4;
   logic pc_plus_4;
   logic pc_plus_4_cy;
   logic pc_plus_4_cy_r;
   logic offset_a;
   logic offset_b;
   logic pc_plus_offset;
   logic pc_plus_offset_cy;
   logic pc_plus_offset_cy_r;
   logic target_aligned;
   logic new_pc;

   assign pc     = o_ibus_adr[0];   // PC rotates through bit 0
   assign plus_4 = i_strobes.cnt2;

   assign {pc_plus_4_cy, pc_plus_4} = {1'b0, pc} + {1'b0, plus_4} + {1'b0, pc_plus_4_cy_r};

   // U-type offset drops the low 12 immediate bits
   assign offset_a = i_pc_rel & pc;
   assign offset_b = i_utype ? (i_imm & i_strobes.cnt12to31) : i_buf;
   assign {pc_plus_offset_cy, pc_plus_offset} =
      {1'b0, offset_a} + {1'b0, offset_b} + {1'b0, pc_plus_offset_cy_r};

   assign target_aligned = pc_plus_offset & !i_strobes.cnt0;

   always_comb begin
      if ((WITH_CSR != 0) && i_trap) begin
         new_pc = i_csr_pc & !i_strobes.cnt0;
      end else if (i_jump) begin
         new_pc = target_aligned;
      end else begin
         new_pc = pc_plus_4;
      end
   end

   assign o_rd_bit     = (i_utype & target_aligned) | (i_jal_or_jalr & pc_plus_4);
   assign o_bad_pc_bit = target_aligned;
   assign o_ibus_cyc   = en_pc_r & !i_strobes.pc_en;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_ibus_adr          <= RESET_PC;
         en_pc_r             <= 1'b1;   // Reset vector fetch pending
         pc_plus_4_cy_r      <= 1'b0;
         pc_plus_offset_cy_r <= 1'b0;
      end else begin
         pc_plus_4_cy_r      <= i_strobes.pc_en & pc_plus_4_cy;
         pc_plus_offset_cy_r <= i_strobes.pc_en & pc_plus_offset_cy;
         if (i_strobes.pc_en) begin
            o_ibus_adr <= {new_pc, o_ibus_adr[31:1]};
            en_pc_r    <= 1'b1;
         end else if (i_ibus_ack) begin
            en_pc_r <= 1'b0;
         end
      end
   end

   a_fetch_aligned: assert property (@(posedge clk) disable iff (i_reset)
      o_ibus_cyc |-> !o_ibus_adr[0]);

endmodule

/* design/pcu_operand_shifter.sv */
`timescale 1ns/1ps

module pcu_operand_shifter (
   input  logic                  clk,
   input  logic                  i_load,
   input  pcu_pkg::pcu_cmd_t     i_cmd,
   input  pcu_pkg::pcu_strobes_t i_strobes,
   output logic                  o_imm_bit,
   output logic                  o_buf_bit,
   output logic                  o_csr_bit
);

   pcu_pkg::pc_word_t imm_sr;
   pcu_pkg::pc_word_t buf_sr;
   pcu_pkg::pc_word_t csr_sr;

   // Immediate for LUI and AUIPC
   always_ff @(posedge clk) begin
      if (i_load) begin
         imm_sr <= i_cmd.imm;
      end else if (i_strobes.pc_en) begin
         imm_sr <= {1'b0, imm_sr[31:1]};
      end
   end

   // Branch or JALR offset
   always_ff @(posedge clk) begin
      if (i_load) begin
         buf_sr <= i_cmd.buf_word;
      end else if (i_strobes.pc_en) begin
         buf_sr <= {1'b0, buf_sr[31:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_load) begin
         csr_sr <= i_cmd.csr_pc;   // Trap vector
      end else if (i_strobes.pc_en) begin
         csr_sr <= {1'b0, csr_sr[31:1]};
      end
   end

   assign o_imm_bit = imm_sr[0];   // LSB first
   assign o_buf_bit = buf_sr[0];
   assign o_csr_bit = csr_sr[0];

endmodule

/* design/pcu_pkg.sv */
package pcu_pkg;

   typedef logic [31:0] pc_word_t;   // PC, operand or result word
   typedef logic [4:0]  bit_cnt_t;   // Position of the serial bit

   // One PC update as decode would hand it over
   typedef struct packed {
      logic     jump;          // Take the target
      logic     jal_or_jalr;   // Result is PC + 4
      logic     utype;         // LUI or AUIPC
      logic     pc_rel;        // Add PC to the offset
      logic     trap;          // Go to trap vector
      pc_word_t imm;
      pc_word_t buf_word;      // Branch or JALR offset
      pc_word_t csr_pc;        // Trap vector
   } pcu_cmd_t;

   typedef struct packed {
      logic pc_en;
      logic cnt0;
      logic cnt1;
      logic cnt2;
      logic cnt12to31;
      logic cnt_done;
   } pcu_strobes_t;

   typedef enum logic {
      SEQ_IDLE,
      SEQ_RUN
   } seq_state_t;

endpackage

/* design/pcu_rd_collector.sv */
`timescale 1ns/1ps

module pcu_rd_collector (
   input  logic                  clk,
   input  logic                  i_reset,
   input  pcu_pkg::pcu_strobes_t i_strobes,
   input  logic                  i_rd_bit,
   input  logic                  i_bad_pc_bit,
   output pcu_pkg::pc_word_t     o_rd_word,
   output logic                  o_misaligned,
   output logic                  o_done
);

   logic [30:0] rd_shift;   // Bits 0..30 of the result
   logic        bad_pc_r;

   always_ff @(posedge clk) begin
      if (i_strobes.pc_en) begin
         rd_shift <= {i_rd_bit, rd_shift[30:1]};
      end
   end

   // Target bit 1 shows up at cnt1
   always_ff @(posedge clk) begin
      if (i_strobes.pc_en & i_strobes.cnt1) begin
         bad_pc_r <= i_bad_pc_bit;
      end
   end

   // Bit 31 arrives with cnt_done
   always_ff @(posedge clk) begin
      if (i_strobes.cnt_done) begin
         o_rd_word    <= {i_rd_bit, rd_shift};
         o_misaligned <= bad_pc_r;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_done <= 1'b0;
      end else begin
         o_done <= i_strobes.cnt_done;
      end
   end

   a_done_single: assert property (@(posedge clk) disable iff (i_reset)
      o_done |=> !o_done);

endmodule

/* design/pcu_sequencer.sv */
`timescale 1ns/1ps

module pcu_sequencer (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_start,
   input  pcu_pkg::pcu_cmd_t     i_cmd,
   input  logic                  i_ibus_cyc,
   output pcu_pkg::pcu_strobes_t o_strobes,
   output logic                  o_busy,
   output pcu_pkg::pcu_cmd_t     o_flags,
   output logic                  o_load
);

   pcu_pkg::seq_state_t state;
   pcu_pkg::bit_cnt_t   cnt;
   pcu_pkg::pcu_cmd_t   cmd_flags;
   logic                last_bit;

   // Start only when idle and no fetch outstanding
   assign o_load   = i_start & (state == pcu_pkg::SEQ_IDLE) & !i_ibus_cyc;
   assign o_busy   = (state == pcu_pkg::SEQ_RUN);
   assign last_bit = (cnt == 5'd31);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state <= pcu_pkg::SEQ_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            pcu_pkg::SEQ_IDLE: begin
               if (o_load) begin
                  state <= pcu_pkg::SEQ_RUN;
               end
            end
            pcu_pkg::SEQ_RUN: begin
               cnt <= cnt + 5'd1;   // Wraps to 0 after bit 31
               if (last_bit) begin
                  state <= pcu_pkg::SEQ_IDLE;
               end
            end
            default: begin
               state <= pcu_pkg::SEQ_IDLE;
            end
         endcase
      end
   end

   // Counter sits at 0 while idle, so only cnt0 can fire outside the window
   always_comb begin
      o_strobes.pc_en     = o_busy;
      o_strobes.cnt0      = (cnt == 5'd0);
      o_strobes.cnt1      = (cnt == 5'd1);
      o_strobes.cnt2      = (cnt == 5'd2);
      o_strobes.cnt12to31 = (cnt >= 5'd12);
      o_strobes.cnt_done  = last_bit;
   end

   // Only the control bits are kept here
   always_comb begin
      cmd_flags          = i_cmd;
      cmd_flags.imm      = '0;
      cmd_flags.buf_word = '0;
      cmd_flags.csr_pc   = '0;
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_flags <= '0;
      end else if (o_load) begin
         o_flags <= cmd_flags;
      end
   end

   a_done_in_window: assert property (@(posedge clk) disable iff (i_reset)
      o_strobes.cnt_done |-> o_strobes.pc_en);

endmodule

/* design/pcu_top.sv */
`timescale 1ns/1ps

module pcu_top #(
   parameter pcu_pkg::pc_word_t RESET_PC = '0,
   parameter int                WITH_CSR = 1
) (
   input  logic              clk,
   input  logic              i_reset,
   input  logic              i_start,
   input  pcu_pkg::pcu_cmd_t i_cmd,
   input  logic              i_ibus_ack,
   output pcu_pkg::pc_word_t o_ibus_adr,
   output logic              o_ibus_cyc,
   output logic              o_busy,
   output logic              o_done,
   output pcu_pkg::pc_word_t o_rd_word,
   output logic              o_misaligned
);

   pcu_pkg::pcu_strobes_t strobes;
   pcu_pkg::pcu_cmd_t     flags;
   logic                  load;
   logic                  imm_bit;
   logic                  buf_bit;
   logic                  csr_bit;
   logic                  rd_bit;
   logic                  bad_pc_bit;

   pcu_sequencer u_sequencer (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_start    (i_start),
      .i_cmd      (i_cmd),
      .i_ibus_cyc (o_ibus_cyc),
      .o_strobes  (strobes),
      .o_busy     (o_busy),
      .o_flags    (flags),
      .o_load     (load)
   );

   pcu_operand_shifter u_shifter (
      .clk       (clk),
      .i_load    (load),
      .i_cmd     (i_cmd),
      .i_strobes (strobes),
      .o_imm_bit (imm_bit),
      .o_buf_bit (buf_bit),
      .o_csr_bit (csr_bit)
   );

   pcu_ctrl #(
      .RESET_PC (RESET_PC),
      .WITH_CSR (WITH_CSR)
   ) u_ctrl (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_strobes     (strobes),
      .i_jump        (flags.jump),
      .i_jal_or_jalr (flags.jal_or_jalr),
      .i_utype       (flags.utype),
      .i_pc_rel      (flags.pc_rel),
      .i_trap        (flags.trap),
      .i_imm         (imm_bit),
      .i_buf         (buf_bit),
      .i_csr_pc      (csr_bit),
      .i_ibus_ack    (i_ibus_ack),
      .o_rd_bit      (rd_bit),
      .o_bad_pc_bit  (bad_pc_bit),
      .o_ibus_adr    (o_ibus_adr),
      .o_ibus_cyc    (o_ibus_cyc)
   );

   pcu_rd_collector u_collector (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_strobes    (strobes),
      .i_rd_bit     (rd_bit),
      .i_bad_pc_bit (bad_pc_bit),
      .o_rd_word    (o_rd_word),
      .o_misaligned (o_misaligned),
      .o_done       (o_done)
   );

endmodule

/* dv/pcu_tb.sv */
`timescale 1ns/1ps

module pcu_tb;

   localparam pcu_pkg::pc_word_t RESET_PC      = 32'h0000_1000;
   localparam int                WITH_CSR      = 1;
   localparam int                DONE_TIMEOUT  = 40;
   localparam int                FETCH_TIMEOUT = 20;

   localparam int KIND_SEQ    = 0;
   localparam int KIND_JAL    = 1;
   localparam int KIND_JALR   = 2;
   localparam int KIND_BRANCH = 3;
   localparam int KIND_LUI    = 4;
   localparam int KIND_AUIPC  = 5;
   localparam int KIND_TRAP   = 6;

   logic              clk;
   logic              i_reset;
   logic              i_start;
   pcu_pkg::pcu_cmd_t i_cmd;
   logic              i_ibus_ack;
   pcu_pkg::pc_word_t o_ibus_adr;
   logic              o_ibus_cyc;
   logic              o_busy;
   logic              o_done;
   pcu_pkg::pc_word_t o_rd_word;
   logic              o_misaligned;

   pcu_pkg::pc_word_t model_pc;   // PC as the model sees it
   int                err_count;
   int                timeout_count;

   pcu_top #(
      .RESET_PC (RESET_PC),
      .WITH_CSR (WITH_CSR)
   ) u_dut (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_start      (i_start),
      .i_cmd        (i_cmd),
      .i_ibus_ack   (i_ibus_ack),
      .o_ibus_adr   (o_ibus_adr),
      .o_ibus_cyc   (o_ibus_cyc),
      .o_busy       (o_busy),
      .o_done       (o_done),
      .o_rd_word    (o_rd_word),
      .o_misaligned (o_misaligned)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Drive and sample just after the rising edge
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check_word(input pcu_pkg::pc_word_t actual,
                             input pcu_pkg::pc_word_t expected, input string name);
      if (actual !== expected) begin
         err_count++;
         $display("ERR %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected, $time);
      end
   endtask

   task automatic check_bit(input logic actual, input logic expected, input string name);
      if (actual !== expected) begin
         err_count++;
         $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      end
   endtask

   function automatic pcu_pkg::pc_word_t calc_target(input pcu_pkg::pcu_cmd_t cmd,
                                                     input pcu_pkg::pc_word_t pc);
      pcu_pkg::pc_word_t base;
      pcu_pkg::pc_word_t offset;
      base   = cmd.pc_rel ? pc : 32'h0;
      offset = cmd.utype ? {cmd.imm[31:12], 12'h000} : cmd.buf_word;
      return (base + offset) & 32'hffff_fffe;
   endfunction

   function automatic pcu_pkg::pc_word_t calc_next_pc(input pcu_pkg::pcu_cmd_t cmd,
                                                      input pcu_pkg::pc_word_t pc);
      if (cmd.trap && (WITH_CSR != 0)) begin
         return cmd.csr_pc & 32'hffff_fffe;
      end else if (cmd.jump) begin
         return calc_target(cmd, pc);
      end
      return pc + 32'd4;
   endfunction

   function automatic pcu_pkg::pc_word_t calc_rd_word(input pcu_pkg::pcu_cmd_t cmd,
                                                      input pcu_pkg::pc_word_t pc);
      if (cmd.utype) begin
         return calc_target(cmd, pc);
      end else if (cmd.jal_or_jalr) begin
         return pc + 32'd4;   // Link address
      end
      return 32'h0;
   endfunction

   function automatic pcu_pkg::pcu_cmd_t make_cmd(input int kind);
      pcu_pkg::pcu_cmd_t cmd;
      logic [31:0]       r;
      cmd          = '0;
      cmd.imm      = $urandom();
      cmd.buf_word = $urandom();
      cmd.csr_pc   = $urandom();
      r            = $urandom();
      case (kind)
         KIND_SEQ: begin
            cmd.jal_or_jalr = r[0];
            cmd.pc_rel      = r[1];
         end
         KIND_JAL: begin
            cmd.jump        = 1'b1;
            cmd.jal_or_jalr = 1'b1;
            cmd.pc_rel      = 1'b1;
            cmd.buf_word    = {{11{r[20]}}, r[20:1], 1'b0};   // 21-bit J offset
         end
         KIND_JALR: begin
            cmd.jump        = 1'b1;
            cmd.jal_or_jalr = 1'b1;   // buf holds rs1 + imm
         end
         KIND_BRANCH: begin
            cmd.jump     = 1'b1;
            cmd.pc_rel   = 1'b1;
            cmd.buf_word = {{19{r[12]}}, r[12:1], 1'b0};   // 13-bit B offset
         end
         KIND_LUI: begin
            cmd.utype = 1'b1;
         end
         KIND_AUIPC: begin
            cmd.utype  = 1'b1;
            cmd.pc_rel = 1'b1;
         end
         default: begin
            cmd.trap   = 1'b1;
            cmd.jump   = r[0];
            cmd.pc_rel = r[1];
         end
      endcase
      return cmd;
   endfunction

   // Start one command and wait for its result
   task automatic run_cmd(input pcu_pkg::pcu_cmd_t cmd, input bit poke);
      pcu_pkg::pc_word_t exp_pc;
      pcu_pkg::pc_word_t exp_rd;
      pcu_pkg::pc_word_t target;
      int                n;
      int                poke_at;
      exp_pc  = calc_next_pc(cmd, model_pc);
      exp_rd  = calc_rd_word(cmd, model_pc);
      target  = calc_target(cmd, model_pc);
      poke_at = $urandom_range(20, 1);
      i_cmd   = cmd;
      i_start = 1'b1;
      step();
      i_start = 1'b0;
      i_cmd   = make_cmd(KIND_TRAP);   // Command already latched
      check_bit(o_busy, 1'b1, "o_busy");
      n = 0;
      while (o_done !== 1'b1 && n < DONE_TIMEOUT) begin
         if (poke && n == poke_at) begin
            i_start = 1'b1;   // Refused while busy
            i_cmd   = make_cmd(KIND_BRANCH);
         end
         step();
         n++;
         i_start = 1'b0;
      end
      if (o_done !== 1'b1) begin
         timeout_count++;
         $display("Timeout: no o_done within %0d cycles of the start", DONE_TIMEOUT);
      end else begin
         if (n != 32) begin
            err_count++;
            $display("o_done came %0d cycles after the start instead of 32", n);
         end
         check_word(o_rd_word, exp_rd, "o_rd_word");
         check_bit(o_misaligned, target[1], "o_misaligned");
         check_bit(o_busy, 1'b0, "o_busy");
         check_bit(o_ibus_cyc, 1'b1, "o_ibus_cyc");   // Fetch request right after the window
         model_pc = exp_pc;
      end
   endtask

   // Instruction bus responder that acks after 0 to 5 cycles
   task automatic serve_fetch(input bit poke);
      int n;
      int delay;
      int i;
      n = 0;
      while (o_ibus_cyc !== 1'b1 && n < FETCH_TIMEOUT) begin
         step();
         n++;
      end
      if (o_ibus_cyc !== 1'b1) begin
         timeout_count++;
         $display("Timeout: no fetch request within %0d cycles", FETCH_TIMEOUT);
      end else begin
         check_word(o_ibus_adr, model_pc, "o_ibus_adr");
         check_bit(o_busy, 1'b0, "o_busy");
         delay = $urandom_range(5, 0);
         if (poke && delay == 0) begin
            delay = 1;   // Room for a refused start
         end
         for (i = 0; i < delay; i++) begin
            if (poke && i == 0) begin
               i_start = 1'b1;
               i_cmd   = make_cmd(KIND_JAL);
            end
            step();
            i_start = 1'b0;
            check_bit(o_ibus_cyc, 1'b1, "o_ibus_cyc");
            check_word(o_ibus_adr, model_pc, "o_ibus_adr");
            check_bit(o_done, 1'b0, "o_done");
         end
         i_ibus_ack = 1'b1;
         step();
         i_ibus_ack = 1'b0;
         check_bit(o_ibus_cyc, 1'b0, "o_ibus_cyc");
      end
   endtask

   // Nothing may happen after a refused start
   task automatic check_quiet(input int cycles);
      int i;
      for (i = 0; i < cycles; i++) begin
         step();
         check_bit(o_done, 1'b0, "o_done");
         check_bit(o_busy, 1'b0, "o_busy");
         check_bit(o_ibus_cyc, 1'b0, "o_ibus_cyc");
      end
      check_word(o_ibus_adr, model_pc, "o_ibus_adr");
   endtask

   initial begin
      int i;
      int kind;
      i_reset       = 1'b1;
      i_start       = 1'b0;
      i_cmd         = '0;
      i_ibus_ack    = 1'b0;
      err_count     = 0;
      timeout_count = 0;
      model_pc      = RESET_PC;
      void'($urandom(96));
      repeat (2) @(posedge clk);
      #1;
      i_reset = 1'b0;

      // Reset vector fetch pending
      check_bit(o_ibus_cyc, 1'b1, "o_ibus_cyc");
      check_word(o_ibus_adr, RESET_PC, "o_ibus_adr");
      check_bit(o_busy, 1'b0, "o_busy");
      check_bit(o_done, 1'b0, "o_done");
      serve_fetch(1'b0);

      for (i = 0; i < 20; i++) begin
         run_cmd(make_cmd(KIND_SEQ), 1'b0);
         serve_fetch(1'b0);
      end

      for (i = 0; i < 30; i++) begin
         kind = $urandom_range(KIND_BRANCH, KIND_JAL);
         run_cmd(make_cmd(kind), 1'b0);
         serve_fetch(1'b0);
      end

      for (i = 0; i < 20; i++) begin
         kind = KIND_LUI + $urandom_range(1, 0);
         run_cmd(make_cmd(kind), 1'b0);
         serve_fetch(1'b0);
      end

      for (i = 0; i < 12; i++) begin
         run_cmd(make_cmd(KIND_TRAP), 1'b0);
         serve_fetch(1'b0);
      end

      // Starts while busy or while the fetch is pending
      for (i = 0; i < 12; i++) begin
         kind = $urandom_range(KIND_TRAP, KIND_SEQ);
         run_cmd(make_cmd(kind), i[0]);
         serve_fetch(!i[0]);
         check_quiet(36);
      end

      $display("Run finished with %0d mismatches and %0d timeouts", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* tb.f */
design/pcu_pkg.sv
design/pcu_sequencer.sv
design/pcu_operand_shifter.sv
design/pcu_ctrl.sv
design/pcu_rd_collector.sv
design/pcu_top.sv
dv/pcu_tb.sv
